// ==== Bender.yml ====
package:
  name: mem_bw

sources:
  # Packages first, then interfaces and the design
  - mem_req_pkg.sv
  - bw_cfg_pkg.sv
  - bw_ifs.sv
  - run_ctrl.sv
  - rd_addr_gen.sv
  - req_fifo.sv
  - rsp_stats.sv
  - mem_bw_top.sv
  - target: simulation
    files:
      - tb_mem_bw.sv

// ==== bw_cfg_pkg.sv ====
package bw_cfg_pkg;

    // ==================================================================
    // Host register file
    // ==================================================================

    localparam int CSR_DATA_BITS = 64;

    // Buffer size reported to the host, in line address bits
    localparam int N_MEM_REGION_BITS = 24;

    typedef logic [CSR_DATA_BITS-1:0] t_csr_data;
    typedef logic [2:0] t_csr_idx;

    // Cycle and event counters
    typedef logic [39:0] t_counter;

    // Stride between consecutive reads, in lines
    typedef logic [15:0] t_stride;

    // Run state machine
    typedef enum logic [1:0]
    {
        ST_IDLE      = 2'd0,
        ST_RUN       = 2'd1,
        ST_TERMINATE = 2'd2
    } t_run_state;

    // Write indices
    // Run word layout: [0] enable reads, [1] shared mode,
    // [17:2] stride, [63:24] cycle count
    localparam t_csr_idx CSR_WR_RUN  = 3'd0;
    localparam t_csr_idx CSR_WR_BASE = 3'd1;
    localparam t_csr_idx CSR_WR_MASK = 3'd2;

    // Read indices, anything else reads zero
    localparam t_csr_idx CSR_RD_INFO  = 3'd0;
    localparam t_csr_idx CSR_RD_BASE  = 3'd1;
    localparam t_csr_idx CSR_RD_REQS  = 3'd2;
    localparam t_csr_idx CSR_RD_RSPS  = 3'd3;
    localparam t_csr_idx CSR_RD_TAGS  = 3'd4;
    localparam t_csr_idx CSR_RD_STATE = 3'd5;

endpackage

// ==== bw_ifs.sv ====
`timescale 1ns/1ps

// ======================================================================
// Run configuration, from the controller to generator and statistics
// ======================================================================
interface run_cfg_if;
    import mem_req_pkg::*;
    import bw_cfg_pkg::*;

    logic start;              // One cycle strobe, a new run begins
    logic running;            // In ST_RUN with reads enabled
    t_run_state state;
    logic shared_mode;
    t_stride stride;
    t_line_addr mem_base;
    t_line_addr mem_mask;
    t_stride offset_base_max; // Largest rotating start offset

    modport ctrl (output start, running, state, shared_mode, stride,
                  mem_base, mem_mask, offset_base_max);

    modport gen (input start, running, shared_mode, stride,
                 mem_base, mem_mask, offset_base_max);

    // Statistics only needs the run boundary and status fields
    modport stats (input start, state, mem_base);
endinterface

// ======================================================================
// Read requests, generator into the request queue
// ======================================================================
interface mem_req_if;
    import mem_req_pkg::*;

    // Single cycle strobe with no ready
    // Producer holds off on the queue's almost full flag instead
    logic valid;
    t_line_addr addr;
    t_tag tag;
    t_rd_op op;

    modport src (output valid, addr, tag, op);
    modport dst (input valid, addr, tag, op);
endinterface

// ==== mem_bw_top.sv ====
`timescale 1ns/1ps

module mem_bw_top
#(
    parameter int FIFO_DEPTH         = 16,
    parameter int FIFO_ALMFULL_SLACK = 4
)
(
    input  logic                    clk,
    input  logic                    reset,

    // Host register writes
    input  logic                    csr_wr_en,
    input  bw_cfg_pkg::t_csr_idx    csr_wr_idx,
    input  bw_cfg_pkg::t_csr_data   csr_wr_data,

    // Host status reads, combinational
    input  bw_cfg_pkg::t_csr_idx    csr_rd_idx,
    output bw_cfg_pkg::t_csr_data   csr_rd_data,

    // Read requests toward memory
    input  logic                    mem_almfull,
    output logic                    req_valid,
    output mem_req_pkg::t_line_addr req_addr,
    output mem_req_pkg::t_tag       req_tag,
    output mem_req_pkg::t_rd_op     req_op,

    // Read responses from memory
    input  logic                    rsp_valid,
    input  mem_req_pkg::t_tag       rsp_tag
);

    logic fifo_almfull;
    logic fifo_empty;

    run_cfg_if cfg_if ();
    mem_req_if req_if ();

    // ==================================================================
    // Control, producer, queue and consumer
    // ==================================================================
    run_ctrl u_run_ctrl
    (
        .clk         (clk),
        .reset       (reset),
        .csr_wr_en   (csr_wr_en),
        .csr_wr_idx  (csr_wr_idx),
        .csr_wr_data (csr_wr_data),
        .fifo_empty  (fifo_empty),
        .cfg         (cfg_if.ctrl)
    );

    rd_addr_gen u_rd_addr_gen
    (
        .clk          (clk),
        .reset        (reset),
        .fifo_almfull (fifo_almfull),
        .cfg          (cfg_if.gen),
        .req          (req_if.src)
    );

    req_fifo
    #(
        .FIFO_DEPTH         (FIFO_DEPTH),
        .FIFO_ALMFULL_SLACK (FIFO_ALMFULL_SLACK)
    )
    u_req_fifo
    (
        .clk         (clk),
        .reset       (reset),
        .mem_almfull (mem_almfull),
        .push        (req_if.dst),
        .almfull     (fifo_almfull),
        .empty       (fifo_empty),
        .req_valid   (req_valid),
        .req_addr    (req_addr),
        .req_tag     (req_tag),
        .req_op      (req_op)
    );

    // Counts the requests actually leaving, not the ones queued
    rsp_stats u_rsp_stats
    (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (req_valid),
        .req_tag     (req_tag),
        .rsp_valid   (rsp_valid),
        .rsp_tag     (rsp_tag),
        .csr_rd_idx  (csr_rd_idx),
        .cfg         (cfg_if.stats),
        .csr_rd_data (csr_rd_data)
    );

endmodule

// ==== mem_req_pkg.sv ====
package mem_req_pkg;

    // ==================================================================
    // Memory request side types
    // ==================================================================

    // Line address width, byte offset within a line is not carried
    localparam int LINE_ADDR_BITS = 42;

    // Request tag, echoed back by memory on the response
    localparam int TAG_BITS = 16;

    typedef logic [LINE_ADDR_BITS-1:0] t_line_addr;
    typedef logic [TAG_BITS-1:0] t_tag;

    // Read opcodes
    // I leaves the line invalid in the cache, S keeps a shared copy
    typedef enum logic
    {
        RD_LINE_I = 1'b0,
        RD_LINE_S = 1'b1
    } t_rd_op;

endpackage

// ==== rd_addr_gen.sv ====
`timescale 1ns/1ps

module rd_addr_gen
(
    input  logic    clk,
    input  logic    reset,
    input  logic    fifo_almfull,
    run_cfg_if.gen  cfg,
    mem_req_if.src  req
);
    import mem_req_pkg::*;
    import bw_cfg_pkg::*;

    logic do_read;
    t_line_addr rd_offset;
    t_line_addr rd_offset_next;
    t_tag rd_tag;

    // Rotating start offset, advanced one cycle after each wrap
    t_stride base_next;
    logic base_upd;

    // Issue decision, the request itself leaves a cycle later
    assign do_read = cfg.running && !fifo_almfull;

    // ==================================================================
    // Offset walk
    // ==================================================================
    always_ff @(posedge clk)
    begin
        // Step the rotating base, back to zero past the limit
        if (base_upd)
        begin
            if (base_next < cfg.offset_base_max)
            begin
                base_next <= base_next + t_stride'(1);
            end
            else
            begin
                base_next <= '0;
            end
        end

        base_upd <= 1'b0;

        if (do_read)
        begin
            rd_offset      <= rd_offset_next;
            rd_offset_next <= rd_offset_next + t_line_addr'(cfg.stride);
            rd_tag         <= rd_tag + t_tag'(1);

            // Next offset left the buffer
            // Restart at the rotating base so every stride keeps the same footprint
            if (|(rd_offset_next & ~cfg.mem_mask))
            begin
                rd_offset      <= t_line_addr'(base_next);
                rd_offset_next <= t_line_addr'(base_next) + t_line_addr'(cfg.stride);
                base_upd       <= 1'b1;
            end
        end

        // New run, the first rotation is scheduled right away
        if (reset || cfg.start)
        begin
            rd_offset      <= '0;
            rd_offset_next <= t_line_addr'(cfg.stride);
            rd_tag         <= '0;
            base_next      <= '0;
            base_upd       <= 1'b1;
        end
    end

    // ==================================================================
    // Request register
    // ==================================================================
    always_ff @(posedge clk)
    begin
        req.valid <= do_read;
        req.addr  <= cfg.mem_base + rd_offset;
        req.tag   <= rd_tag;
        req.op    <= cfg.shared_mode ? RD_LINE_S : RD_LINE_I;

        if (reset)
        begin
            req.valid <= 1'b0;
        end
    end

    // Queue slack assumes the producer reacts to almost full in one cycle
    a_almfull_hold: assert property (@(posedge clk) disable iff (reset)
        fifo_almfull |=> !req.valid);

endmodule

// ==== req_fifo.sv ====
`timescale 1ns/1ps

module req_fifo
#(
    parameter int FIFO_DEPTH         = 16,
    parameter int FIFO_ALMFULL_SLACK = 4
)
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    mem_almfull,
    mem_req_if.dst                  push,
    output logic                    almfull,
    output logic                    empty,
    output logic                    req_valid,
    output mem_req_pkg::t_line_addr req_addr,
    output mem_req_pkg::t_tag       req_tag,
    output mem_req_pkg::t_rd_op     req_op
);
    import mem_req_pkg::*;

    localparam int PTR_BITS = $clog2(FIFO_DEPTH);
    localparam int CNT_BITS = PTR_BITS + 1;

    // Entry storage, split by field
    t_line_addr addr_mem [FIFO_DEPTH];
    t_tag tag_mem [FIFO_DEPTH];
    t_rd_op op_mem [FIFO_DEPTH];

    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic pop;

    // Drain one entry per cycle while memory has room
    assign pop = (count != '0) && !mem_almfull;

    // Free entries below the slack covers requests still in flight
    assign almfull = (CNT_BITS'(FIFO_DEPTH) - count) < CNT_BITS'(FIFO_ALMFULL_SLACK);

    // Nothing stored and nothing arriving
    assign empty = (count == '0) && !push.valid;

    // ==================================================================
    // Storage and pointers
    // ==================================================================
    always_ff @(posedge clk)
    begin
        if (push.valid)
        begin
            addr_mem[wr_ptr] <= push.addr;
            tag_mem[wr_ptr]  <= push.tag;
            op_mem[wr_ptr]   <= push.op;
            wr_ptr <= wr_ptr + PTR_BITS'(1);
        end

        if (pop)
        begin
            rd_ptr <= rd_ptr + PTR_BITS'(1);
        end

        count <= count + CNT_BITS'(push.valid) - CNT_BITS'(pop);

        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
    end

    // Output register, one entry presented per pop
    always_ff @(posedge clk)
    begin
        req_valid <= pop;
        req_addr  <= addr_mem[rd_ptr];
        req_tag   <= tag_mem[rd_ptr];
        req_op    <= op_mem[rd_ptr];

        if (reset)
        begin
            req_valid <= 1'b0;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        push.valid |-> (count != CNT_BITS'(FIFO_DEPTH)));

endmodule

// ==== rsp_stats.sv ====
`timescale 1ns/1ps

module rsp_stats
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req_valid,
    input  mem_req_pkg::t_tag     req_tag,
    input  logic                  rsp_valid,
    input  mem_req_pkg::t_tag     rsp_tag,
    input  bw_cfg_pkg::t_csr_idx  csr_rd_idx,
    run_cfg_if.stats              cfg,
    output bw_cfg_pkg::t_csr_data csr_rd_data
);
    import mem_req_pkg::*;
    import bw_cfg_pkg::*;

    t_counter cnt_req;
    t_counter cnt_rsp;
    t_tag last_req_tag;
    t_tag last_rsp_tag;

    // ==================================================================
    // Event counters
    // ==================================================================
    always_ff @(posedge clk)
    begin
        // Requests as they leave toward memory
        if (req_valid)
        begin
            cnt_req      <= cnt_req + t_counter'(1);
            last_req_tag <= req_tag;
        end

        // Responses as they come back
        if (rsp_valid)
        begin
            cnt_rsp      <= cnt_rsp + t_counter'(1);
            last_rsp_tag <= rsp_tag;
        end

        // Each run starts counting from zero
        if (reset || cfg.start)
        begin
            cnt_req      <= '0;
            cnt_rsp      <= '0;
            last_req_tag <= '0;
            last_rsp_tag <= '0;
        end
    end

    // ==================================================================
    // Status read port
    // ==================================================================
    always_comb
    begin
        case (csr_rd_idx)
            CSR_RD_INFO:  csr_rd_data = t_csr_data'(N_MEM_REGION_BITS);
            CSR_RD_BASE:  csr_rd_data = t_csr_data'(cfg.mem_base);
            CSR_RD_REQS:  csr_rd_data = t_csr_data'(cnt_req);
            CSR_RD_RSPS:  csr_rd_data = t_csr_data'(cnt_rsp);
            // Response tag in the upper half
            CSR_RD_TAGS:  csr_rd_data = t_csr_data'({last_rsp_tag, last_req_tag});
            CSR_RD_STATE: csr_rd_data = t_csr_data'(cfg.state);
            default:      csr_rd_data = '0;
        endcase
    end

endmodule

// ==== run_ctrl.sv ====
`timescale 1ns/1ps

module run_ctrl
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  csr_wr_en,
    input  bw_cfg_pkg::t_csr_idx  csr_wr_idx,
    input  bw_cfg_pkg::t_csr_data csr_wr_data,
    input  logic                  fifo_empty,
    run_cfg_if.ctrl               cfg
);
    import mem_req_pkg::*;
    import bw_cfg_pkg::*;

    logic run_wr;
    logic enable_reads;
    t_counter cycles_rem;

    // Run word write, also the source of the start strobe
    assign run_wr = csr_wr_en && (csr_wr_idx == CSR_WR_RUN);

    // ==================================================================
    // Register writes
    // ==================================================================
    always_ff @(posedge clk)
    begin
        if (csr_wr_en && (csr_wr_idx == CSR_WR_BASE))
        begin
            cfg.mem_base <= t_line_addr'(csr_wr_data);
        end

        if (csr_wr_en && (csr_wr_idx == CSR_WR_MASK))
        begin
            cfg.mem_mask <= t_line_addr'(csr_wr_data);
        end

        // Run fields, cycle count is handled with the countdown
        if (run_wr)
        begin
            enable_reads    <= csr_wr_data[0];
            cfg.shared_mode <= csr_wr_data[1];
            cfg.stride      <= csr_wr_data[17:2];
        end

        if (reset)
        begin
            cfg.mem_base    <= '0;
            cfg.mem_mask    <= '0;
            enable_reads    <= 1'b0;
            cfg.shared_mode <= 1'b0;
            cfg.stride      <= '0;
        end
    end

    // Cycle countdown
    // Loaded with the run word, free running down to zero
    always_ff @(posedge clk)
    begin
        if (cycles_rem != t_counter'(0))
        begin
            cycles_rem <= cycles_rem - t_counter'(1);
        end

        // A new load wins over the decrement
        if (run_wr)
        begin
            cycles_rem <= csr_wr_data[63:24];
        end

        if (reset)
        begin
            cycles_rem <= '0;
        end
    end

    // Largest start offset when the pointer wraps to the buffer head
    // One line below the stride, kept inside the buffer
    always_ff @(posedge clk)
    begin
        cfg.offset_base_max <= (cfg.stride == t_stride'(0)) ? t_stride'(0) :
            ((cfg.stride - t_stride'(1)) & t_stride'(cfg.mem_mask));
    end

    // ==================================================================
    // Run state machine
    // ==================================================================
    always_ff @(posedge clk)
    begin
        cfg.start <= run_wr;

        case (cfg.state)
            ST_IDLE:
            begin
                if (cfg.start)
                begin
                    cfg.state <= ST_RUN;
                end
            end

            ST_RUN:
            begin
                // Out of cycles, stop issuing
                if (cycles_rem == t_counter'(0))
                begin
                    cfg.state <= ST_TERMINATE;
                end
            end

            ST_TERMINATE:
            begin
                // Wait for the queue to drain toward memory
                if (fifo_empty)
                begin
                    cfg.state <= ST_IDLE;
                end
            end

            default:
            begin
                cfg.state <= ST_IDLE;
            end
        endcase

        if (reset)
        begin
            cfg.start <= 1'b0;
            cfg.state <= ST_IDLE;
        end
    end

    // Generator may only issue in ST_RUN with reads switched on
    assign cfg.running = (cfg.state == ST_RUN) && enable_reads;

    // Only a start strobe gets the machine out of idle
    a_idle_exit: assert property (@(posedge clk) disable iff (reset)
        (cfg.state == ST_IDLE && !cfg.start) |=> (cfg.state == ST_IDLE));

endmodule

// ==== sim.f ====
mem_req_pkg.sv
bw_cfg_pkg.sv
bw_ifs.sv
run_ctrl.sv
rd_addr_gen.sv
req_fifo.sv
rsp_stats.sv
mem_bw_top.sv
tb_mem_bw.sv

// ==== tb_mem_bw.sv ====
`timescale 1ns/1ps

module tb_mem_bw;
    import mem_req_pkg::*;
    import bw_cfg_pkg::*;

    localparam int FIFO_DEPTH         = 16;
    localparam int FIFO_ALMFULL_SLACK = 4;
    localparam int N_RUNS             = 5;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;
    localparam t_line_addr BUF_MASK   = t_line_addr'(32'h1f);

    logic clk;
    logic reset;
    logic csr_wr_en;
    t_csr_idx csr_wr_idx;
    t_csr_data csr_wr_data;
    t_csr_idx csr_rd_idx;
    t_csr_data csr_rd_data;
    logic mem_almfull;
    logic req_valid;
    t_line_addr req_addr;
    t_tag req_tag;
    t_rd_op req_op;
    logic rsp_valid;
    t_tag rsp_tag;

    // Random source and bookkeeping
    logic [31:0] lfsr = 32'h893b270e;
    int tests = 0;
    int checks = 0;
    int errors = 0;
    int wd_limit = 0;
    int cyc = 0;
    int n_seen = 0;
    logic almfull_prev = 1'b0;

    // Last response tag seen by the DUT in the current run
    t_tag last_rsp_seen = '0;

    // Per run settings drawn before reset is released
    int run_stride [N_RUNS];
    t_counter run_cycles [N_RUNS];
    logic run_shared [N_RUNS];
    logic run_enable [N_RUNS];

    // Expected requests as {addr, tag, op} in issue order
    logic [58:0] exp_q [$];

    // Memory responder tags with the cycle each is due
    t_tag rsp_q [$];
    int due_q [$];

    // Reference model state
    logic m_start;
    t_run_state m_state;
    t_counter m_cycles;
    logic m_enable;
    logic m_shared;
    t_stride m_stride;
    t_stride m_obm;
    t_stride m_base_next;
    logic m_base_upd;
    t_line_addr m_base;
    t_line_addr m_mask;
    t_line_addr m_off;
    t_line_addr m_off_next;
    t_tag m_tag;
    logic m_push;
    int m_count;

    mem_bw_top
    #(
        .FIFO_DEPTH         (FIFO_DEPTH),
        .FIFO_ALMFULL_SLACK (FIFO_ALMFULL_SLACK)
    )
    u_dut
    (
        .clk         (clk),
        .reset       (reset),
        .csr_wr_en   (csr_wr_en),
        .csr_wr_idx  (csr_wr_idx),
        .csr_wr_data (csr_wr_data),
        .csr_rd_idx  (csr_rd_idx),
        .csr_rd_data (csr_rd_data),
        .mem_almfull (mem_almfull),
        .req_valid   (req_valid),
        .req_addr    (req_addr),
        .req_tag     (req_tag),
        .req_op      (req_op),
        .rsp_valid   (rsp_valid),
        .rsp_tag     (rsp_tag)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ==================================================================
    // Random numbers and checks
    // ==================================================================

    // Galois LFSR stepped once per bit
    function automatic logic rand_bit();
        logic lsb;
        lsb = lfsr[0];
        lfsr = lfsr >> 1;
        if (lsb)
            lfsr = lfsr ^ LFSR_TAPS;
        return lsb;
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++)
            v = (v << 1) | int'(rand_bit());
        return v;
    endfunction

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond)
        else
        begin
            $display("%s", what);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before)
            $display("test %0d %s: ok", tests, name);
        else
            $display("test %0d %s: %0d errors", tests, name, errors - errs_before);
    endtask

    // Host register access with one write or read per call
    task automatic write_csr(input t_csr_idx idx, input t_csr_data data);
        @(posedge clk);
        csr_wr_en   <= 1'b1;
        csr_wr_idx  <= idx;
        csr_wr_data <= data;
        @(posedge clk);
        csr_wr_en <= 1'b0;
    endtask

    task automatic read_csr(input t_csr_idx idx, output t_csr_data data);
        @(posedge clk);
        csr_rd_idx <= idx;
        @(negedge clk);
        data = csr_rd_data;
    endtask

    // ==================================================================
    // Memory side back-pressure and in-order responses
    // ==================================================================
    always @(posedge clk)
    begin : mem_responder
        int due;
        cyc = cyc + 1;
        // Roughly one cycle in four
        mem_almfull <= (rand_bits(2) == 3);
        if (reset)
        begin
            rsp_valid <= 1'b0;
            rsp_q.delete();
            due_q.delete();
        end
        else
        begin
            if (req_valid)
            begin
                due = cyc + 1 + rand_bits(3);
                if (due_q.size() != 0 && due < due_q[$])
                    due = due_q[$];
                rsp_q.push_back(req_tag);
                due_q.push_back(due);
            end
            if (rsp_q.size() != 0 && due_q[0] <= cyc)
            begin
                rsp_valid <= 1'b1;
                rsp_tag   <= rsp_q.pop_front();
                void'(due_q.pop_front());
            end
            else
                rsp_valid <= 1'b0;
        end
    end

    // Response tags as they reach the DUT
    always @(posedge clk)
    begin : rsp_track
        if (reset)
            last_rsp_seen = '0;
        else if (rsp_valid)
            last_rsp_seen = rsp_tag;
    end

    // ==================================================================
    // Reference model stepped cycle by cycle from the register and queue rules
    // ==================================================================
    always @(posedge clk)
    begin : ref_model
        logic run_wr;
        logic do_read;
        logic pop;
        logic empty;
        logic wrap;
        t_stride base_step;
        if (reset)
        begin
            m_start     = 1'b0;
            m_state     = ST_IDLE;
            m_cycles    = '0;
            m_enable    = 1'b0;
            m_shared    = 1'b0;
            m_stride    = '0;
            m_obm       = '0;
            m_base_next = '0;
            m_base_upd  = 1'b1;
            m_base      = '0;
            m_mask      = '0;
            m_off       = '0;
            m_off_next  = '0;
            m_tag       = '0;
            m_push      = 1'b0;
            m_count     = 0;
            exp_q.delete();
        end
        else
        begin
            run_wr  = csr_wr_en && (csr_wr_idx == CSR_WR_RUN);
            do_read = (m_state == ST_RUN) && m_enable
                      && !((FIFO_DEPTH - m_count) < FIFO_ALMFULL_SLACK);
            pop     = (m_count != 0) && !mem_almfull;
            empty   = (m_count == 0) && !m_push;
            m_count = m_count + int'(m_push) - int'(pop);

            // Rotating base steps one cycle after a wrap
            base_step = m_base_next;
            if (m_base_upd)
                base_step = (m_base_next < m_obm) ? m_base_next + t_stride'(1) : '0;

            wrap = |(m_off_next & ~m_mask);
            m_base_upd = do_read && wrap;
            if (do_read)
            begin
                exp_q.push_back({m_base + m_off, m_tag, m_shared ? RD_LINE_S : RD_LINE_I});
                m_tag = m_tag + t_tag'(1);
                if (wrap)
                begin
                    m_off      = t_line_addr'(m_base_next);
                    m_off_next = t_line_addr'(m_base_next) + t_line_addr'(m_stride);
                end
                else
                begin
                    m_off      = m_off_next;
                    m_off_next = m_off_next + t_line_addr'(m_stride);
                end
            end
            m_base_next = base_step;
            m_push = do_read;

            // New run restarts the walk
            if (m_start)
            begin
                m_off       = '0;
                m_off_next  = t_line_addr'(m_stride);
                m_tag       = '0;
                m_base_next = '0;
                m_base_upd  = 1'b1;
            end

            case (m_state)
                ST_IDLE:      if (m_start) m_state = ST_RUN;
                ST_RUN:       if (m_cycles == '0) m_state = ST_TERMINATE;
                ST_TERMINATE: if (empty) m_state = ST_IDLE;
                default:      m_state = ST_IDLE;
            endcase

            if (m_cycles != '0)
                m_cycles = m_cycles - t_counter'(1);
            if (run_wr)
                m_cycles = csr_wr_data[63:24];
            m_start = run_wr;

            m_obm = (m_stride == '0) ? '0 : ((m_stride - t_stride'(1)) & m_mask[15:0]);

            if (csr_wr_en && (csr_wr_idx == CSR_WR_BASE))
                m_base = t_line_addr'(csr_wr_data);
            if (csr_wr_en && (csr_wr_idx == CSR_WR_MASK))
                m_mask = t_line_addr'(csr_wr_data);
            if (run_wr)
            begin
                m_enable = csr_wr_data[0];
                m_shared = csr_wr_data[1];
                m_stride = csr_wr_data[17:2];
            end
        end
    end

    // Requests leaving the DUT are compared in order
    always @(negedge clk)
    begin : req_check
        logic [58:0] exp_e;
        if (!reset && req_valid)
        begin
            n_seen++;
            check_true(!almfull_prev,
                "req_valid was high right after a cycle with mem_almfull high");
            if (exp_q.size() == 0)
                check_true(1'b0, "req_valid was high with no request expected");
            else
            begin
                exp_e = exp_q.pop_front();
                check_val("req_addr", 64'(req_addr), 64'(exp_e[58:17]));
                check_val("req_tag", 64'(req_tag), 64'(exp_e[16:1]));
                check_val("req_op", 64'(req_op), 64'(exp_e[0]));
            end
        end
        almfull_prev = mem_almfull;
    end

    // ==================================================================
    // Runs
    // ==================================================================
    task automatic do_run(input int r);
        t_csr_data rd;
        t_csr_data word;
        t_tag last_tag;
        int errs0;
        errs0  = errors;
        n_seen = 0;
        last_rsp_seen = '0;
        word = {run_cycles[r], 6'd0, t_stride'(run_stride[r]), run_shared[r], run_enable[r]};
        write_csr(CSR_WR_RUN, word);

        // Wait for the run to begin and then for the queue to drain
        do
            read_csr(CSR_RD_STATE, rd);
        while (rd[1:0] == ST_IDLE);
        do
            read_csr(CSR_RD_STATE, rd);
        while (rd[1:0] != ST_IDLE);

        check_true(exp_q.size() == 0, "a predicted request never left the DUT");
        if (run_enable[r])
            check_true(n_seen > 0, "a run with reads enabled issued no request");
        else
            check_val("req_valid count", 64'(n_seen), 64'(0));

        // Tags count up from zero in each run
        last_tag = (n_seen == 0) ? t_tag'(0) : t_tag'(n_seen - 1);

        // Responses may still be in flight, so the two halves differ here
        read_csr(CSR_RD_TAGS, rd);
        check_val("csr_rd_data tags", rd, {32'd0, last_rsp_seen, last_tag});
        read_csr(CSR_RD_REQS, rd);
        check_val("csr_rd_data reqs", rd, 64'(n_seen));
        read_csr(CSR_RD_BASE, rd);
        check_val("csr_rd_data base", rd, 64'(m_base));

        // Counters settle one cycle after the last response
        while (rsp_q.size() != 0)
            @(negedge clk);
        repeat (2) @(posedge clk);
        read_csr(CSR_RD_RSPS, rd);
        check_val("csr_rd_data rsps", rd, 64'(n_seen));
        read_csr(CSR_RD_TAGS, rd);
        check_val("csr_rd_data tags", rd, {32'd0, last_tag, last_tag});

        report_test($sformatf("run stride %0d cycles %0d reads %0d, %0d requests",
                    run_stride[r], run_cycles[r], run_enable[r], n_seen), errs0);
    endtask

    initial
    begin : watchdog
        wait (wd_limit != 0);
        repeat (wd_limit) @(posedge clk);
        $display("timeout: the test did not finish within %0d cycles", wd_limit);
        $display("sim failed");
        $finish;
    end

    initial
    begin : main
        t_csr_data rd;
        int errs0;
        int limit;
        reset       = 1'b1;
        csr_wr_en   = 1'b0;
        csr_wr_idx  = '0;
        csr_wr_data = '0;
        csr_rd_idx  = '0;
        mem_almfull = 1'b0;
        rsp_valid   = 1'b0;
        rsp_tag     = '0;

        // Strides 1 and 3, one buffer length and a random one before a run with reads off
        for (int r = 0; r < N_RUNS; r++)
        begin
            run_cycles[r] = t_counter'(40 + rand_bits(6));
            run_shared[r] = rand_bit();
            run_enable[r] = (r != N_RUNS - 1);
            run_stride[r] = 1 + rand_bits(5);
        end
        run_stride[0] = 1;
        run_stride[1] = 3;
        run_stride[2] = int'(BUF_MASK) + 1;

        // Reset phase counts as one extra empty run
        limit = 4 * (FIFO_DEPTH + 20);
        for (int r = 0; r < N_RUNS; r++)
            limit += 4 * (int'(run_cycles[r]) + FIFO_DEPTH + 20);
        wd_limit = limit;

        repeat (8) @(posedge clk);
        reset <= 1'b0;

        errs0 = errors;
        read_csr(CSR_RD_INFO, rd);
        check_val("csr_rd_data info", rd, 64'd24);
        read_csr(CSR_RD_STATE, rd);
        check_val("csr_rd_data state", rd, 64'(ST_IDLE));
        read_csr(CSR_RD_REQS, rd);
        check_val("csr_rd_data reqs", rd, 64'(0));
        read_csr(CSR_RD_RSPS, rd);
        check_val("csr_rd_data rsps", rd, 64'(0));
        read_csr(CSR_RD_TAGS, rd);
        check_val("csr_rd_data tags", rd, 64'(0));
        check_true(n_seen == 0, "req_valid went high with no run started");
        report_test("status after reset", errs0);

        write_csr(CSR_WR_BASE, t_csr_data'(20'h5a000 + rand_bits(12)));
        write_csr(CSR_WR_MASK, t_csr_data'(BUF_MASK));
        for (int r = 0; r < N_RUNS; r++)
            do_run(r);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule
